// File: Makefile
TOP = data_cache_array_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module $(TOP) -f flist.f

sim:
	verilator --binary --timing --top-module $(TOP) -f flist.f -Mdir obj_dir
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "Verification failed" sim.log; then exit 1; fi
	@grep -q "Verification passed" sim.log

clean:
	rm -rf obj_dir sim.log

// File: design/cache_control_pkg.sv
`default_nettype none

package cache_control_pkg;

    // Port 0 operation, one per cycle.
    typedef enum logic [1:0] {
        OP_IDLE  = 2'b00,
        OP_READ  = 2'b01,
        OP_WRITE = 2'b10
    } port_op_t;

    // Line fields touched by a port 0 access.
    // A cleared bit leaves that memory alone on write and read.
    typedef struct packed {
        logic valid;
        logic dirty;
        logic tag;
        logic data;
    } field_access_t;

endpackage : cache_control_pkg

`default_nettype wire

// File: design/cache_packet_pkg.sv
`default_nettype none

package cache_packet_pkg;

    // ****************************************
    // Line field widths.
    // ****************************************

    // Stored tag bits.
    localparam int TAG_WIDTH  = 20;

    // One data word, split into bytes for partial writes.
    localparam int WORD_WIDTH = 32;
    localparam int PORT_BYTES = 4;

    // ****************************************
    // Cache packet.
    // ****************************************

    // Unit moved in and out of a way, one word of the line at a time.
    typedef struct packed {
        logic                    valid;
        logic                    dirty;
        logic [TAG_WIDTH - 1:0]  tag;
        logic [WORD_WIDTH - 1:0] word;
    } data_cache_packet_t;

endpackage : cache_packet_pkg

`default_nettype wire

// File: design/data_cache_array.sv
`timescale 1ns/1ps
`default_nettype none

module data_cache_array
    import cache_packet_pkg::*;
    import cache_control_pkg::*;
#(
    parameter int INDEX_WIDTH = 4,
    parameter int CHIPS       = 4,
    parameter int WAYS        = 2,
    localparam int OFFSET_WIDTH = (CHIPS > 1) ? $clog2(CHIPS) : 1
) (
    input  logic                      clk_i,
    input  logic                      rst_i,

    // Port 0, maintenance access.
    input  port_op_t                  port0_op_i,
    input  logic [WAYS - 1:0]         port0_way_i,
    input  field_access_t             port0_fields_i,
    input  logic [PORT_BYTES - 1:0]   port0_byte_write_i,
    input  logic [INDEX_WIDTH - 1:0]  port0_index_i,
    input  logic [OFFSET_WIDTH - 1:0] port0_offset_i,
    input  data_cache_packet_t        port0_packet_i,
    output data_cache_packet_t        port0_packet_o,

    // Port 1, lookup.
    input  logic                      port1_read_i,
    input  logic [INDEX_WIDTH - 1:0]  port1_index_i,
    input  logic [OFFSET_WIDTH - 1:0] port1_offset_i,
    input  logic [TAG_WIDTH - 1:0]    port1_tag_i,
    output logic                      port1_hit_o,
    output logic [WAYS - 1:0]         port1_hit_way_o,
    output data_cache_packet_t        port1_packet_o
);

    logic [CHIPS - 1:0]     port0_write_chips;
    logic [CHIPS - 1:0]     port0_read_chips;
    logic [CHIPS - 1:0]     port1_read_chips;
    logic [WAYS - 1:0]      port0_way_q;
    logic                   port1_read_q;
    logic [TAG_WIDTH - 1:0] port1_tag_q;
    logic [WAYS - 1:0]      hit_vector;
    logic [WAYS - 1:0]      hit_first;
    data_cache_packet_t     hit_packet;
    data_cache_packet_t     port0_way_packet [WAYS];
    data_cache_packet_t     port1_way_packet [WAYS];

    // Offset to one-hot chip, qualified by the operation.
    assign port0_write_chips = (port0_op_i == OP_WRITE) ? CHIPS'(1) << port0_offset_i : '0;
    assign port0_read_chips  = (port0_op_i == OP_READ) ? CHIPS'(1) << port0_offset_i : '0;
    assign port1_read_chips  = port1_read_i ? CHIPS'(1) << port1_offset_i : '0;

    for (genvar w = 0; w < WAYS; w++) begin : g_way
        data_cache_way #(
            .INDEX_WIDTH ( INDEX_WIDTH ),
            .CHIPS       ( CHIPS       )
        ) i_data_cache_way (
            .clk_i                 ( clk_i               ),
            .rst_i                 ( rst_i               ),
            .enable_way_i          ( port0_way_i[w]      ),
            .fields_i              ( port0_fields_i      ),
            .byte_write_i          ( port0_byte_write_i  ),
            .port0_write_address_i ( port0_index_i       ),
            .port0_cache_packet_i  ( port0_packet_i      ),
            .port0_write_i         ( port0_write_chips   ),
            .port0_read_address_i  ( port0_index_i       ),
            .port0_read_i          ( port0_read_chips    ),
            .port0_cache_packet_o  ( port0_way_packet[w] ),
            .port1_read_address_i  ( port1_index_i       ),
            .port1_read_i          ( port1_read_chips    ),
            .port1_cache_packet_o  ( port1_way_packet[w] )
        );
    end

    // ****************************************
    // Port 0 way select.
    // ****************************************

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            port0_way_q <= '0;
        end else if (port0_op_i == OP_READ) begin
            port0_way_q <= port0_way_i;
        end
    end

    always_comb begin
        port0_packet_o = '0;
        for (int w = 0; w < WAYS; w++) begin
            if (port0_way_q[w]) begin
                port0_packet_o = port0_way_packet[w];
            end
        end
    end

    // ****************************************
    // Port 1 tag compare and hit select.
    // ****************************************

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            port1_read_q <= 1'b0;
        end else begin
            port1_read_q <= port1_read_i;
        end
    end

    // Tag travels with the read, memories answer one edge later.
    always_ff @(posedge clk_i) begin
        if (port1_read_i) begin
            port1_tag_q <= port1_tag_i;
        end
    end

    always_comb begin
        hit_vector = '0;
        for (int w = 0; w < WAYS; w++) begin
            hit_vector[w] = port1_way_packet[w].valid && (port1_way_packet[w].tag == port1_tag_q);
        end
    end

    // Lowest hit way wins.
    assign hit_first = hit_vector & (~hit_vector + WAYS'(1));

    always_comb begin
        hit_packet = '0;
        for (int w = 0; w < WAYS; w++) begin
            if (hit_first[w]) begin
                hit_packet = port1_way_packet[w];
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            port1_hit_o     <= 1'b0;
            port1_hit_way_o <= '0;
            port1_packet_o  <= '0;
        end else if (port1_read_q) begin
            port1_hit_o     <= |hit_vector;
            port1_hit_way_o <= hit_first;
            port1_packet_o  <= hit_packet;
        end
    end

endmodule : data_cache_array

`default_nettype wire

// File: design/data_cache_block.sv
`timescale 1ns/1ps
`default_nettype none

module data_cache_block
    import cache_packet_pkg::*;
#(
    parameter int INDEX_WIDTH = 4,
    parameter int CHIPS       = 4
) (
    input  logic                     clk_i,
    input  logic [PORT_BYTES - 1:0]  byte_write_i,

    // Port 0, read and write.
    input  logic [INDEX_WIDTH - 1:0] port0_write_address_i,
    input  logic [WORD_WIDTH - 1:0]  port0_data_i,
    input  logic [CHIPS - 1:0]       port0_write_i,
    input  logic [INDEX_WIDTH - 1:0] port0_read_address_i,
    input  logic [CHIPS - 1:0]       port0_read_i,
    output logic [WORD_WIDTH - 1:0]  port0_data_o,

    // Port 1, read only.
    input  logic [INDEX_WIDTH - 1:0] port1_read_address_i,
    input  logic [CHIPS - 1:0]       port1_read_i,
    output logic [WORD_WIDTH - 1:0]  port1_data_o
);

    localparam int DEPTH      = 2 ** INDEX_WIDTH;
    localparam int BYTE_WIDTH = WORD_WIDTH / PORT_BYTES;

    logic [WORD_WIDTH - 1:0] port0_chip_data [CHIPS];
    logic [WORD_WIDTH - 1:0] port1_chip_data [CHIPS];
    logic [CHIPS - 1:0]      port0_chip_q;
    logic [CHIPS - 1:0]      port1_chip_q;

    // ****************************************
    // Word chips, one per word of the line.
    // ****************************************

    for (genvar c = 0; c < CHIPS; c++) begin : g_chip
        logic [WORD_WIDTH - 1:0] chip_ram [DEPTH];

        always_ff @(posedge clk_i) begin
            if (port0_write_i[c]) begin
                for (int b = 0; b < PORT_BYTES; b++) begin
                    if (byte_write_i[b]) begin
                        chip_ram[port0_write_address_i][b * BYTE_WIDTH +: BYTE_WIDTH] <=
                            port0_data_i[b * BYTE_WIDTH +: BYTE_WIDTH];
                    end
                end
            end
            if (port0_read_i[c]) begin
                port0_chip_data[c] <= chip_ram[port0_read_address_i];
            end
            if (port1_read_i[c]) begin
                port1_chip_data[c] <= chip_ram[port1_read_address_i];
            end
        end
    end

    // ****************************************
    // Output word select.
    // ****************************************

    // Chip choice follows the read it belongs to.
    always_ff @(posedge clk_i) begin
        if (|port0_read_i) begin
            port0_chip_q <= port0_read_i;
        end
        if (|port1_read_i) begin
            port1_chip_q <= port1_read_i;
        end
    end

    always_comb begin
        port0_data_o = '0;
        port1_data_o = '0;
        for (int c = 0; c < CHIPS; c++) begin
            if (port0_chip_q[c]) begin
                port0_data_o = port0_chip_data[c];
            end
            if (port1_chip_q[c]) begin
                port1_data_o = port1_chip_data[c];
            end
        end
    end

endmodule : data_cache_block

`default_nettype wire

// File: design/data_cache_way.sv
`timescale 1ns/1ps
`default_nettype none

module data_cache_way
    import cache_packet_pkg::*;
    import cache_control_pkg::*;
#(
    parameter int INDEX_WIDTH = 4,
    parameter int CHIPS       = 4
) (
    input  logic                     clk_i,
    input  logic                     rst_i,
    input  logic                     enable_way_i,
    input  field_access_t            fields_i,
    input  logic [PORT_BYTES - 1:0]  byte_write_i,

    // Port 0, read and write.
    input  logic [INDEX_WIDTH - 1:0] port0_write_address_i,
    input  data_cache_packet_t       port0_cache_packet_i,
    input  logic [CHIPS - 1:0]       port0_write_i,
    input  logic [INDEX_WIDTH - 1:0] port0_read_address_i,
    input  logic [CHIPS - 1:0]       port0_read_i,
    output data_cache_packet_t       port0_cache_packet_o,

    // Port 1, read only.
    input  logic [INDEX_WIDTH - 1:0] port1_read_address_i,
    input  logic [CHIPS - 1:0]       port1_read_i,
    output data_cache_packet_t       port1_cache_packet_o
);

    logic [CHIPS - 1:0] port0_write;
    logic [CHIPS - 1:0] port0_read;
    logic               port0_any_write;
    logic               port0_any_read;
    logic               port1_any_read;

    // Port 0 only reaches the selected way.
    assign port0_write     = port0_write_i & {CHIPS{enable_way_i}};
    assign port0_read      = port0_read_i & {CHIPS{enable_way_i}};
    assign port0_any_write = |port0_write;
    assign port0_any_read  = |port0_read;
    assign port1_any_read  = |port1_read_i;

    // Status and tag are per line, so any active chip strobes them.
    status_memory #(
        .INDEX_WIDTH ( INDEX_WIDTH )
    ) i_status_memory (
        .clk_i                 ( clk_i                              ),
        .rst_i                 ( rst_i                              ),
        .port0_write_address_i ( port0_write_address_i              ),
        .port0_valid_i         ( port0_cache_packet_i.valid         ),
        .port0_dirty_i         ( port0_cache_packet_i.dirty         ),
        .port0_valid_write_i   ( port0_any_write & fields_i.valid   ),
        .port0_dirty_write_i   ( port0_any_write & fields_i.dirty   ),
        .port0_read_address_i  ( port0_read_address_i               ),
        .port0_valid_read_i    ( port0_any_read & fields_i.valid    ),
        .port0_dirty_read_i    ( port0_any_read & fields_i.dirty    ),
        .port0_valid_o         ( port0_cache_packet_o.valid         ),
        .port0_dirty_o         ( port0_cache_packet_o.dirty         ),
        .port1_read_address_i  ( port1_read_address_i               ),
        .port1_read_i          ( port1_any_read                     ),
        .port1_valid_o         ( port1_cache_packet_o.valid         ),
        .port1_dirty_o         ( port1_cache_packet_o.dirty         )
    );

    tag_memory #(
        .INDEX_WIDTH ( INDEX_WIDTH )
    ) i_tag_memory (
        .clk_i                 ( clk_i                          ),
        .port0_write_address_i ( port0_write_address_i          ),
        .port0_tag_i           ( port0_cache_packet_i.tag       ),
        .port0_write_i         ( port0_any_write & fields_i.tag ),
        .port0_read_address_i  ( port0_read_address_i           ),
        .port0_read_i          ( port0_any_read & fields_i.tag  ),
        .port0_tag_o           ( port0_cache_packet_o.tag       ),
        .port1_read_address_i  ( port1_read_address_i           ),
        .port1_read_i          ( port1_any_read                 ),
        .port1_tag_o           ( port1_cache_packet_o.tag       )
    );

    // Only the data block picks a chip.
    data_cache_block #(
        .INDEX_WIDTH ( INDEX_WIDTH ),
        .CHIPS       ( CHIPS       )
    ) i_data_cache_block (
        .clk_i                 ( clk_i                                 ),
        .byte_write_i          ( byte_write_i                          ),
        .port0_write_address_i ( port0_write_address_i                 ),
        .port0_data_i          ( port0_cache_packet_i.word             ),
        .port0_write_i         ( port0_write & {CHIPS{fields_i.data}}  ),
        .port0_read_address_i  ( port0_read_address_i                  ),
        .port0_read_i          ( port0_read & {CHIPS{fields_i.data}}   ),
        .port0_data_o          ( port0_cache_packet_o.word             ),
        .port1_read_address_i  ( port1_read_address_i                  ),
        .port1_read_i          ( port1_read_i                          ),
        .port1_data_o          ( port1_cache_packet_o.word             )
    );

endmodule : data_cache_way

`default_nettype wire

// File: design/status_memory.sv
`timescale 1ns/1ps
`default_nettype none

module status_memory #(
    parameter int INDEX_WIDTH = 4
) (
    input  logic                     clk_i,
    input  logic                     rst_i,

    // Port 0, read and write.
    input  logic [INDEX_WIDTH - 1:0] port0_write_address_i,
    input  logic                     port0_valid_i,
    input  logic                     port0_dirty_i,
    input  logic                     port0_valid_write_i,
    input  logic                     port0_dirty_write_i,
    input  logic [INDEX_WIDTH - 1:0] port0_read_address_i,
    input  logic                     port0_valid_read_i,
    input  logic                     port0_dirty_read_i,
    output logic                     port0_valid_o,
    output logic                     port0_dirty_o,

    // Port 1, read only.
    input  logic [INDEX_WIDTH - 1:0] port1_read_address_i,
    input  logic                     port1_read_i,
    output logic                     port1_valid_o,
    output logic                     port1_dirty_o
);

    localparam int DEPTH = 2 ** INDEX_WIDTH;

    logic [DEPTH - 1:0] valid_bits;
    logic [DEPTH - 1:0] dirty_bits;

    // Invalidate-all in a single cycle.
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            valid_bits    <= '0;
            port0_valid_o <= 1'b0;
            port0_dirty_o <= 1'b0;
            port1_valid_o <= 1'b0;
            port1_dirty_o <= 1'b0;
        end else begin
            if (port0_valid_write_i) begin
                valid_bits[port0_write_address_i] <= port0_valid_i;
            end
            if (port0_valid_read_i) begin
                port0_valid_o <= valid_bits[port0_read_address_i];
            end
            if (port0_dirty_read_i) begin
                port0_dirty_o <= dirty_bits[port0_read_address_i];
            end
            // Old contents win against a port 0 write.
            if (port1_read_i) begin
                port1_valid_o <= valid_bits[port1_read_address_i];
                port1_dirty_o <= dirty_bits[port1_read_address_i];
            end
        end
    end

    // Dirty bit only means something while valid is set
    always_ff @(posedge clk_i) begin
        if (port0_dirty_write_i) begin
            dirty_bits[port0_write_address_i] <= port0_dirty_i;
        end
    end

endmodule : status_memory

`default_nettype wire

// File: design/tag_memory.sv
`timescale 1ns/1ps
`default_nettype none

module tag_memory
    import cache_packet_pkg::*;
#(
    parameter int INDEX_WIDTH = 4
) (
    input  logic                     clk_i,

    // Port 0, read and write.
    input  logic [INDEX_WIDTH - 1:0] port0_write_address_i,
    input  logic [TAG_WIDTH - 1:0]   port0_tag_i,
    input  logic                     port0_write_i,
    input  logic [INDEX_WIDTH - 1:0] port0_read_address_i,
    input  logic                     port0_read_i,
    output logic [TAG_WIDTH - 1:0]   port0_tag_o,

    // Port 1, read only.
    input  logic [INDEX_WIDTH - 1:0] port1_read_address_i,
    input  logic                     port1_read_i,
    output logic [TAG_WIDTH - 1:0]   port1_tag_o
);

    localparam int DEPTH = 2 ** INDEX_WIDTH;

    logic [TAG_WIDTH - 1:0] tag_ram [DEPTH];

    // One write port, two registered read ports.
    // Reads see the contents from before this edge's write.
    always_ff @(posedge clk_i) begin
        if (port0_write_i) begin
            tag_ram[port0_write_address_i] <= port0_tag_i;
        end
        if (port0_read_i) begin
            port0_tag_o <= tag_ram[port0_read_address_i];
        end
        if (port1_read_i) begin
            port1_tag_o <= tag_ram[port1_read_address_i];
        end
    end

endmodule : tag_memory

`default_nettype wire

// File: dv/data_cache_array_tb.sv
`timescale 1ns/1ps
`default_nettype none

module data_cache_array_tb
    import cache_packet_pkg::*;
    import cache_control_pkg::*;
();

    localparam int INDEX_WIDTH  = 4;
    localparam int CHIPS        = 4;
    localparam int WAYS         = 2;
    localparam int OFFSET_WIDTH = 2;
    localparam int DEPTH        = 2 ** INDEX_WIDTH;
    localparam int WAIT_LIMIT   = 16;

    localparam field_access_t ALL_FIELDS = '{valid: 1'b1, dirty: 1'b1, tag: 1'b1, data: 1'b1};
    localparam field_access_t DATA_ONLY  = '{valid: 1'b0, dirty: 1'b0, tag: 1'b0, data: 1'b1};
    localparam field_access_t DIRTY_ONLY = '{valid: 1'b0, dirty: 1'b1, tag: 1'b0, data: 1'b0};
    localparam field_access_t TAG_ONLY   = '{valid: 1'b0, dirty: 1'b0, tag: 1'b1, data: 1'b0};

    logic                      clk = 1'b0;
    logic                      rst;
    port_op_t                  port0_op;
    logic [WAYS - 1:0]         port0_way;
    field_access_t             port0_fields;
    logic [PORT_BYTES - 1:0]   port0_byte_write;
    logic [INDEX_WIDTH - 1:0]  port0_index;
    logic [OFFSET_WIDTH - 1:0] port0_offset;
    data_cache_packet_t        port0_packet_in;
    data_cache_packet_t        port0_packet_out;
    logic                      port1_read;
    logic [INDEX_WIDTH - 1:0]  port1_index;
    logic [OFFSET_WIDTH - 1:0] port1_offset;
    logic [TAG_WIDTH - 1:0]    port1_tag;
    logic                      port1_hit;
    logic [WAYS - 1:0]         port1_hit_way;
    data_cache_packet_t        port1_packet_out;

    // Expected line contents with status and tag repeated per word.
    data_cache_packet_t model [WAYS][DEPTH][CHIPS];
    logic [31:0]        lcg_state = 32'd12457;

    data_cache_array #(
        .INDEX_WIDTH ( INDEX_WIDTH ),
        .CHIPS       ( CHIPS       ),
        .WAYS        ( WAYS        )
    ) i_data_cache_array (
        .clk_i              ( clk              ),
        .rst_i              ( rst              ),
        .port0_op_i         ( port0_op         ),
        .port0_way_i        ( port0_way        ),
        .port0_fields_i     ( port0_fields     ),
        .port0_byte_write_i ( port0_byte_write ),
        .port0_index_i      ( port0_index      ),
        .port0_offset_i     ( port0_offset     ),
        .port0_packet_i     ( port0_packet_in  ),
        .port0_packet_o     ( port0_packet_out ),
        .port1_read_i       ( port1_read       ),
        .port1_index_i      ( port1_index      ),
        .port1_offset_i     ( port1_offset     ),
        .port1_tag_i        ( port1_tag        ),
        .port1_hit_o        ( port1_hit        ),
        .port1_hit_way_o    ( port1_hit_way    ),
        .port1_packet_o     ( port1_packet_out )
    );

    initial begin
        forever #20 clk = ~clk;
    end

    // ****************************************
    // Helpers and checks.
    // ****************************************

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    function automatic data_cache_packet_t random_packet();
        data_cache_packet_t p;
        logic [31:0]        r;
        r       = next_random();
        p.valid = 1'b1;
        p.dirty = r[31];
        p.tag   = r[30:11];
        p.word  = next_random();
        return p;
    endfunction

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("Verification failed");
        $fatal(1, "Stopping at the first error.");
    endtask

    task automatic wait_cycles(input int count);
        int waited;
        waited = 0;
        while (waited < count) begin
            if (waited >= WAIT_LIMIT) begin
                report_failure("Timeout: a wait on the clock ran past its cycle limit.");
            end
            @(negedge clk);
            waited++;
        end
    endtask

    task automatic compare_packet(input string name, input data_cache_packet_t actual,
                                  input data_cache_packet_t expected);
        if (actual !== expected) begin
            report_failure($sformatf("Mismatch at %0t ns: %s is %h, expected %h",
                                     $time, name, actual, expected));
        end
    endtask

    task automatic compare_hit(input logic hit, input logic [WAYS - 1:0] hit_way,
                               input logic exp_hit, input logic [WAYS - 1:0] exp_way);
        if (hit !== exp_hit) begin
            report_failure($sformatf("Mismatch at %0t ns: port1_hit_o is %b, expected %b",
                                     $time, hit, exp_hit));
        end else if (hit_way !== exp_way) begin
            report_failure($sformatf("Mismatch at %0t ns: port1_hit_way_o is %b, expected %b",
                                     $time, hit_way, exp_way));
        end
    endtask

    task automatic drive_idle();
        port0_op         = OP_IDLE;
        port0_way        = '0;
        port0_fields     = '0;
        port0_byte_write = '0;
        port0_index      = '0;
        port0_offset     = '0;
        port0_packet_in  = '0;
        port1_read       = 1'b0;
        port1_index      = '0;
        port1_offset     = '0;
        port1_tag        = '0;
    endtask

    task automatic apply_reset();
        rst = 1'b1;
        wait_cycles(2);
        rst = 1'b0;
    endtask

    // Status and tag belong to the line and the word to one offset.
    task automatic model_write(input int w, input field_access_t fields,
                               input logic [PORT_BYTES - 1:0] bytes, input int index,
                               input int offset, input data_cache_packet_t p);
        for (int o = 0; o < CHIPS; o++) begin
            if (fields.valid) model[w][index][o].valid = p.valid;
            if (fields.dirty) model[w][index][o].dirty = p.dirty;
            if (fields.tag) model[w][index][o].tag = p.tag;
        end
        for (int b = 0; b < PORT_BYTES; b++) begin
            if (fields.data && bytes[b]) begin
                model[w][index][offset].word[b * 8 +: 8] = p.word[b * 8 +: 8];
            end
        end
    endtask

    // Lowest valid way with a matching tag wins and a miss gives a zero packet.
    task automatic expected_lookup(input int index, input int offset,
                                   input logic [TAG_WIDTH - 1:0] tag, output logic hit,
                                   output logic [WAYS - 1:0] hit_way,
                                   output data_cache_packet_t p);
        hit     = 1'b0;
        hit_way = '0;
        p       = '0;
        for (int w = 0; w < WAYS; w++) begin
            if (!hit && model[w][index][offset].valid && model[w][index][offset].tag == tag) begin
                hit        = 1'b1;
                hit_way[w] = 1'b1;
                p          = model[w][index][offset];
            end
        end
    endtask

    task automatic drive_port0(input port_op_t op, input int w, input field_access_t fields,
                               input logic [PORT_BYTES - 1:0] bytes, input int index,
                               input int offset, input data_cache_packet_t p);
        port0_op         = op;
        port0_way        = WAYS'(1) << w;
        port0_fields     = fields;
        port0_byte_write = bytes;
        port0_index      = INDEX_WIDTH'(index);
        port0_offset     = OFFSET_WIDTH'(offset);
        port0_packet_in  = p;
    endtask

    task automatic drive_lookup(input int index, input int offset,
                                input logic [TAG_WIDTH - 1:0] tag);
        port1_read   = 1'b1;
        port1_index  = INDEX_WIDTH'(index);
        port1_offset = OFFSET_WIDTH'(offset);
        port1_tag    = tag;
    endtask

    task automatic port0_write(input int w, input field_access_t fields,
                               input logic [PORT_BYTES - 1:0] bytes, input int index,
                               input int offset, input data_cache_packet_t p);
        drive_port0(OP_WRITE, w, fields, bytes, index, offset, p);
        wait_cycles(1);
        drive_idle();
        model_write(w, fields, bytes, index, offset, p);
    endtask

    task automatic check_port0_read(input int w, input int index, input int offset);
        drive_port0(OP_READ, w, ALL_FIELDS, '0, index, offset, '0);
        wait_cycles(1);
        drive_idle();
        compare_packet("port0_packet_o", port0_packet_out, model[w][index][offset]);
    endtask

    task automatic check_lookup(input int index, input int offset,
                                input logic [TAG_WIDTH - 1:0] tag);
        logic               exp_hit;
        logic [WAYS - 1:0]  exp_way;
        data_cache_packet_t exp_packet;
        expected_lookup(index, offset, tag, exp_hit, exp_way, exp_packet);
        drive_lookup(index, offset, tag);
        wait_cycles(1);
        drive_idle();
        wait_cycles(1);
        compare_hit(port1_hit, port1_hit_way, exp_hit, exp_way);
        compare_packet("port1_packet_o", port1_packet_out, exp_packet);
    endtask

    // ****************************************
    // Directed tests.
    // ****************************************

    task automatic test_full_write_read();
        for (int w = 0; w < WAYS; w++) begin
            for (int i = 0; i < DEPTH; i++) begin
                for (int o = 0; o < CHIPS; o++) begin
                    port0_write(w, ALL_FIELDS, 4'hF, i, o, random_packet());
                    check_port0_read(w, i, o);
                end
            end
        end
    endtask

    // Contents survive reset while the valid bits clear.
    task automatic test_reset_invalidates();
        apply_reset();
        for (int w = 0; w < WAYS; w++) begin
            for (int i = 0; i < DEPTH; i++) begin
                for (int o = 0; o < CHIPS; o++) begin
                    model[w][i][o].valid = 1'b0;
                end
            end
        end
        for (int i = 0; i < DEPTH; i++) begin
            check_lookup(i, i % CHIPS, model[0][i][0].tag);
            for (int w = 0; w < WAYS; w++) begin
                for (int o = 0; o < CHIPS; o++) begin
                    check_port0_read(w, i, o);
                end
            end
        end
    endtask

    task automatic test_field_mask();
        data_cache_packet_t p;
        p       = random_packet();
        p.dirty = ~model[1][3][0].dirty;
        port0_write(1, DIRTY_ONLY, 4'hF, 3, 1, p);
        for (int o = 0; o < CHIPS; o++) begin
            check_port0_read(1, 3, o);
        end
        port0_write(1, DATA_ONLY, 4'hF, 3, 2, random_packet());
        for (int o = 0; o < CHIPS; o++) begin
            check_port0_read(1, 3, o);
        end
    endtask

    task automatic test_byte_enables();
        logic [31:0] r;
        repeat (12) begin
            r = next_random();
            port0_write(int'(r[31]), DATA_ONLY, r[15:12], int'(r[27:24]), int'(r[21:20]),
                        random_packet());
            check_port0_read(int'(r[31]), int'(r[27:24]), int'(r[21:20]));
        end
    endtask

    task automatic test_lookup(output logic [TAG_WIDTH - 1:0] tag_a);
        data_cache_packet_t pa;
        data_cache_packet_t pb;
        pa     = random_packet();
        pb     = random_packet();
        pb.tag = ~pa.tag;
        port0_write(0, ALL_FIELDS, 4'hF, 9, 0, pa);
        port0_write(1, ALL_FIELDS, 4'hF, 9, 1, pb);
        for (int o = 0; o < CHIPS; o++) begin
            check_lookup(9, o, pa.tag);
            check_lookup(9, o, pb.tag);
            check_lookup(9, o, pa.tag ^ 20'h5a5a5);
        end
        tag_a = pa.tag;
    endtask

    // Lookup in the write cycle still sees the old tag.
    task automatic test_collision(input logic [TAG_WIDTH - 1:0] old_tag);
        logic               exp_hit;
        logic [WAYS - 1:0]  exp_way;
        data_cache_packet_t exp_packet;
        data_cache_packet_t p;
        p     = random_packet();
        p.tag = old_tag ^ 20'h00f0f;
        expected_lookup(9, 0, old_tag, exp_hit, exp_way, exp_packet);
        drive_port0(OP_WRITE, 0, TAG_ONLY, 4'hF, 9, 0, p);
        drive_lookup(9, 0, old_tag);
        wait_cycles(1);
        drive_idle();
        model_write(0, TAG_ONLY, 4'hF, 9, 0, p);
        wait_cycles(1);
        compare_hit(port1_hit, port1_hit_way, exp_hit, exp_way);
        compare_packet("port1_packet_o", port1_packet_out, exp_packet);
        check_lookup(9, 0, p.tag);
        check_lookup(9, 0, old_tag);
    endtask

    initial begin
        logic [TAG_WIDTH - 1:0] tag_a;
        drive_idle();
        apply_reset();
        for (int i = 0; i < DEPTH; i++) begin
            check_lookup(i, i % CHIPS, 20'h0);
        end
        test_full_write_read();
        test_reset_invalidates();
        test_field_mask();
        test_byte_enables();
        test_lookup(tag_a);
        test_collision(tag_a);
        $display("Verification passed");
        $finish;
    end

endmodule : data_cache_array_tb

`default_nettype wire

// File: flist.f
design/cache_packet_pkg.sv
design/cache_control_pkg.sv
design/status_memory.sv
design/tag_memory.sv
design/data_cache_block.sv
design/data_cache_way.sv
design/data_cache_array.sv
dv/data_cache_array_tb.sv
